//--- verilog/cpubus_pkg.sv
`default_nettype none

package cpubus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes and timing
    ////////////////////////////////////////////////////////////////////////////

    localparam int bm_addr_w  = 20;  // Internal bus-master address
    localparam int mem_addr_w = 12;  // 4 KiB with upper bits ignored
    localparam int mem_wait   = 3;   // Strobe to ack, in clk cycles

    // CPU-visible register map
    localparam logic [2:0] reg_addr_lo  = 3'd0;
    localparam logic [2:0] reg_addr_mid = 3'd1;
    localparam logic [2:0] reg_addr_hi  = 3'd2;  // Step code in upper nibble
    localparam logic [2:0] reg_port0    = 3'd3;
    localparam logic [2:0] reg_port1    = 3'd4;
    localparam logic [2:0] reg_ctrl     = 3'd5;
    localparam logic [2:0] reg_ien      = 3'd6;
    localparam logic [2:0] reg_isr      = 3'd7;

    // Terminal counts of the bus clock divider with the slowest last
    localparam logic [7:0][4:0] clkdiv_max_table = {
        5'd31, 5'd24, 5'd12, 5'd9, 5'd6, 5'd4, 5'd3, 5'd2
    };

    // Code 0 holds the pointer and code n adds 2^(n-1)
    function automatic logic [bm_addr_w-1:0] incr_step(input logic [3:0] code);
        incr_step = (code == 4'd0) ? '0 : bm_addr_w'(1) << (code - 4'd1);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Bus-master and bus-clock bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [bm_addr_w-1:0] addr;
        logic [7:0]           wrdata;
        logic                 write;
        logic                 strobe;  // Held until ack
    } bm_req_t;

    typedef struct packed {
        logic [7:0] rddata;  // Valid while ack is high
        logic       ack;
    } bm_rsp_t;

    typedef struct packed {
        logic phi2;
        logic rise;  // One clk after phi2 goes high
        logic fall;  // One clk after phi2 goes low
    } phi2_evt_t;

endpackage

`default_nettype wire

//--- verilog/phi2_clkgen.sv
`default_nettype none
`timescale 1ns/100ps

module phi2_clkgen
    import cpubus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] clkdiv_sel,
    input  logic       busy,
    output logic       phi2_n,
    output phi2_evt_t  evt
);

    logic [4:0] cnt;
    logic [4:0] cnt_max;
    logic       phi2;
    logic [1:0] phi2_q;  // [1] is the older sample

    assign cnt_max = clkdiv_max_table[clkdiv_sel];

    // Count up, stall at the top while an internal access is open
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (cnt == cnt_max) begin
            if (!busy)
                cnt <= '0;
        end else begin
            cnt <= cnt + 5'd1;
        end
    end

    assign phi2   = (cnt != 5'd0);
    assign phi2_n = !phi2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            phi2_q <= 2'b00;
        else
            phi2_q <= {phi2_q[0], phi2};
    end

    assign evt.phi2 = phi2;
    assign evt.rise = (phi2_q == 2'b01);
    assign evt.fall = (phi2_q == 2'b10);

    // Bus clock never drops while an internal access is open
    a_stretch: assert property (@(posedge clk) disable iff (rst)
        busy |-> phi2);

endmodule

`default_nettype wire

//--- verilog/cpubus_regs.sv
`default_nettype none
`timescale 1ns/100ps

module cpubus_regs
    import cpubus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  phi2_evt_t  evt,
    input  logic       cs_n,
    input  logic       rw_n,
    input  logic [2:0] a,
    input  logic [7:0] d_in,
    output logic [7:0] d_out,
    output logic       d_oe,
    input  logic [7:0] irqs,
    output logic       irq_n,
    output logic       warmboot,
    output logic [2:0] clkdiv_sel,
    output logic       busy,
    output bm_req_t    bm_req,
    input  bm_rsp_t    bm_rsp
);

    // Two pointers indexed by port or by the select bit
    logic [1:0][bm_addr_w-1:0] ptr_r, ptr_next;
    logic [1:0][3:0]           code_r, code_next;

    logic       sel_r, sel_next;
    logic [2:0] clkdiv_r, clkdiv_next;
    logic       warm_r, warm_next;
    logic [7:0] ien_r, ien_next;
    logic [7:0] isr_r, isr_next;

    bm_req_t    req_r, req_next;
    logic [7:0] rddata_r, rddata_next;  // Last acked read byte
    logic       busy_r, busy_next;

    logic       do_read;
    logic       do_write;
    logic       is_port;
    logic       port;                   // 0 = pointer 0, 1 = pointer 1
    logic       start;
    logic [7:0] port_data;

    ////////////////////////////////////////////////////////////////////////////
    // CPU side decode
    ////////////////////////////////////////////////////////////////////////////

    assign do_read  = evt.fall && !cs_n && rw_n;   // Start of a read cycle
    assign do_write = evt.rise && !cs_n && !rw_n;  // Data is stable by now
    assign is_port  = (a == reg_port0) || (a == reg_port1);
    assign port     = (a == reg_port1);
    assign start    = (do_read || do_write) && is_port;

    assign port_data = bm_rsp.ack ? bm_rsp.rddata : rddata_r;

    always_comb begin
        case (a)
            reg_addr_lo:  d_out = ptr_r[sel_r][7:0];
            reg_addr_mid: d_out = ptr_r[sel_r][15:8];
            reg_addr_hi:  d_out = {code_r[sel_r], ptr_r[sel_r][19:16]};
            reg_port0,
            reg_port1:    d_out = port_data;
            reg_ctrl:     d_out = {warm_r, 3'b000, clkdiv_r, sel_r};
            reg_ien:      d_out = ien_r;
            default:      d_out = isr_r;
        endcase
    end

    assign d_oe = !cs_n && rw_n;

    ////////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        ptr_next    = ptr_r;
        code_next   = code_r;
        sel_next    = sel_r;
        clkdiv_next = clkdiv_r;
        warm_next   = warm_r;
        ien_next    = ien_r;
        isr_next    = isr_r;
        req_next    = req_r;
        rddata_next = rddata_r;
        busy_next   = busy_r;

        if (bm_rsp.ack) begin
            rddata_next     = bm_rsp.rddata;
            req_next.strobe = 1'b0;
            busy_next       = 1'b0;
        end

        if (do_write) begin
            case (a)
                reg_addr_lo:  ptr_next[sel_r][7:0]   = d_in;
                reg_addr_mid: ptr_next[sel_r][15:8]  = d_in;
                reg_addr_hi: begin
                    code_next[sel_r]       = d_in[7:4];
                    ptr_next[sel_r][19:16] = d_in[3:0];
                end
                reg_ctrl: begin
                    warm_next   = d_in[7];
                    clkdiv_next = d_in[3:1];
                    sel_next    = d_in[0];
                end
                reg_ien:      ien_next = d_in;
                reg_isr:      isr_next = isr_r & ~d_in;  // Write one to clear
                default:      ;                          // Ports handled below
            endcase
        end

        isr_next = isr_next | irqs;  // Sticky and sampled every clock

        // Port access at current pointer, then step it
        if (start) begin
            req_next.addr   = ptr_r[port];
            req_next.write  = do_write;
            req_next.strobe = 1'b1;
            if (do_write)
                req_next.wrdata = d_in;
            ptr_next[port] = ptr_r[port] + incr_step(code_r[port]);
            busy_next      = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr_r    <= '0;
            code_r   <= '0;
            sel_r    <= 1'b0;
            clkdiv_r <= 3'd0;
            warm_r   <= 1'b0;
            ien_r    <= 8'h00;
            isr_r    <= 8'h00;
            req_r    <= '0;
            rddata_r <= 8'h00;
            busy_r   <= 1'b0;
        end else begin
            ptr_r    <= ptr_next;
            code_r   <= code_next;
            sel_r    <= sel_next;
            clkdiv_r <= clkdiv_next;
            warm_r   <= warm_next;
            ien_r    <= ien_next;
            isr_r    <= isr_next;
            req_r    <= req_next;
            rddata_r <= rddata_next;
            busy_r   <= busy_next;
        end
    end

    // Request goes out in the cycle of the bus event
    assign bm_req     = req_next;
    assign busy       = busy_next;
    assign irq_n      = ~|(isr_r & ien_r);
    assign warmboot   = warm_r;
    assign clkdiv_sel = clkdiv_r;

    // One outstanding request that only the memory releases
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy_r);

    a_busy_ack: assert property (@(posedge clk) disable iff (rst)
        bm_rsp.ack |-> busy_r);

endmodule

`default_nettype wire

//--- verilog/byte_mem_slave.sv
`default_nettype none
`timescale 1ns/100ps

module byte_mem_slave
    import cpubus_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  bm_req_t bm_req,
    output bm_rsp_t bm_rsp
);

    logic [7:0] mem [2**mem_addr_w];

    logic                  strobe_q;
    logic                  pending;
    logic [3:0]            wait_cnt;
    logic                  take;
    logic [mem_addr_w-1:0] addr_q;
    logic [7:0]            wrdata_q;
    logic                  write_q;

    assign take = bm_req.strobe && !strobe_q && !pending;  // New request

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            strobe_q <= 1'b0;
            pending  <= 1'b0;
            wait_cnt <= 4'd0;
        end else begin
            strobe_q <= bm_req.strobe;
            if (take) begin
                pending  <= 1'b1;
                wait_cnt <= 4'(mem_wait - 1);
            end else if (bm_rsp.ack) begin
                pending  <= 1'b0;
            end else if (pending) begin
                wait_cnt <= wait_cnt - 4'd1;
            end
        end
    end

    // Request payload with the address wrapping at 4 KiB
    always_ff @(posedge clk) begin
        if (take) begin
            addr_q   <= bm_req.addr[mem_addr_w-1:0];
            wrdata_q <= bm_req.wrdata;
            write_q  <= bm_req.write;
        end
        if (bm_rsp.ack && write_q)
            mem[addr_q] <= wrdata_q;  // Commit at ack
    end

    assign bm_rsp.ack    = pending && (wait_cnt == 4'd0);
    assign bm_rsp.rddata = mem[addr_q];

    a_ack_req: assert property (@(posedge clk) disable iff (rst)
        bm_rsp.ack |-> $past(bm_req.strobe, mem_wait));

    a_ack_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(bm_req.strobe) |-> ##mem_wait bm_rsp.ack);

endmodule

`default_nettype wire

//--- verilog/cpubus_bridge_top.sv
`default_nettype none
`timescale 1ns/100ps

module cpubus_bridge_top
    import cpubus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cs_n,
    input  logic       rw_n,
    input  logic [2:0] a,
    input  logic [7:0] d_in,
    input  logic [7:0] irqs,
    output logic       phi2_n,
    output logic [7:0] d_out,
    output logic       d_oe,
    output logic       irq_n,
    output logic       warmboot
);

    phi2_evt_t  evt;
    logic [2:0] clkdiv_sel;
    logic       busy;       // Stretches phi2 high
    bm_req_t    bm_req;
    bm_rsp_t    bm_rsp;

    phi2_clkgen u_clkgen (
        .clk        (clk),
        .rst        (rst),
        .clkdiv_sel (clkdiv_sel),
        .busy       (busy),
        .phi2_n     (phi2_n),
        .evt        (evt)
    );

    cpubus_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .evt        (evt),
        .cs_n       (cs_n),
        .rw_n       (rw_n),
        .a          (a),
        .d_in       (d_in),
        .d_out      (d_out),
        .d_oe       (d_oe),
        .irqs       (irqs),
        .irq_n      (irq_n),
        .warmboot   (warmboot),
        .clkdiv_sel (clkdiv_sel),
        .busy       (busy),
        .bm_req     (bm_req),
        .bm_rsp     (bm_rsp)
    );

    byte_mem_slave u_mem (
        .clk    (clk),
        .rst    (rst),
        .bm_req (bm_req),
        .bm_rsp (bm_rsp)
    );

endmodule

`default_nettype wire

//--- dv/cpubus_checker.sv
`default_nettype none
`timescale 1ns/100ps

// Expected values in the tests file follow the pointer step rule
// Step code 0 keeps the pointer, code n adds 2^(n-1), wrapping at 2^20
module cpubus_checker
    import cpubus_pkg::*;
(
    input  logic       clk,
    input  logic       phi2_n,
    input  logic       cs_n,
    input  logic       rw_n,
    input  logic [2:0] a,
    input  logic [7:0] d_out,
    input  logic       d_oe,
    input  logic       irq_n,
    input  logic       warmboot,
    output int         errors,
    output int         checks,
    output int         seen
);

    localparam int max_lines = 128;

    logic [7:0]      op_q   [max_lines];
    logic [7:0]      exp_q  [max_lines];
    logic [8*32-1:0] name_q [max_lines];
    int              n_lines;

    task automatic load_tests;
        int fd;
        int cnt;
        string line;
        logic [7:0] op;
        logic [7:0] r;
        logic [7:0] d;
        logic [7:0] e;
        logic [8*32-1:0] nm;
        n_lines = 0;
        fd = $fopen("dv/cpubus_tests.txt", "r");
        if (fd == 0)
            return;
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0)
                break;
            cnt = $sscanf(line, "%c %h %h %h %s", op, r, d, e, nm);
            if (cnt == 5 && n_lines < max_lines) begin
                op_q[n_lines]   = op;
                exp_q[n_lines]  = e;
                name_q[n_lines] = nm;
                n_lines = n_lines + 1;
            end
        end
        $fclose(fd);
    endtask

    task automatic compare(input logic [8*32-1:0] nm, input logic [7:0] exp_v,
                           input logic [7:0] act_v);
        checks = checks + 1;
        if (act_v !== exp_v) begin
            $display("FAILED %0s expected %02h actual %02h", nm, exp_v, act_v);
            errors = errors + 1;
        end
    endtask

    task automatic check_line(input int idx);
        if (op_q[idx] == "W") begin
            if (d_oe !== 1'b0) begin
                $display("data bus driven during write cycle of %0s", name_q[idx]);
                errors = errors + 1;
            end
        end else begin
            if (d_oe !== 1'b1) begin
                $display("data bus not driven during read cycle of %0s", name_q[idx]);
                errors = errors + 1;
            end
            if (op_q[idx] == "Q")
                compare(name_q[idx], exp_q[idx], {7'd0, irq_n});  // IRQ level
            else
                compare(name_q[idx], exp_q[idx], d_out);
            if (op_q[idx] == "R" && a == reg_ctrl)
                compare(name_q[idx], {7'd0, exp_q[idx][7]}, {7'd0, warmboot});
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sample at the falling clock after each phi2 fall
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        errors = 0;
        checks = 0;
        seen   = 0;
        load_tests();
        forever begin
            @(posedge phi2_n);
            @(negedge clk);
            if (!cs_n && seen < n_lines) begin  // Idle cycles carry no line
                check_line(seen);
                seen = seen + 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_cpubus.sv
`default_nettype none
`timescale 1ns/100ps

module tb_cpubus;

    localparam int max_lines = 128;
    localparam int cycle_ns  = 8;

    logic       clk;
    logic       rst;
    logic       cs_n;
    logic       rw_n;
    logic [2:0] a;
    logic [7:0] d_in;
    logic [7:0] irqs;
    logic       phi2_n;
    logic [7:0] d_out;
    logic       d_oe;
    logic       irq_n;
    logic       warmboot;

    logic [7:0] op_q   [max_lines];
    logic [7:0] reg_q  [max_lines];
    logic [7:0] data_q [max_lines];
    int         n_lines;
    logic       loaded;
    int         seed;
    logic [31:0] rnd;
    int         i;

    int errors;
    int checks;
    int seen;

    cpubus_bridge_top UUT (
        .clk      (clk),
        .rst      (rst),
        .cs_n     (cs_n),
        .rw_n     (rw_n),
        .a        (a),
        .d_in     (d_in),
        .irqs     (irqs),
        .phi2_n   (phi2_n),
        .d_out    (d_out),
        .d_oe     (d_oe),
        .irq_n    (irq_n),
        .warmboot (warmboot)
    );

    cpubus_checker u_check (
        .clk      (clk),
        .phi2_n   (phi2_n),
        .cs_n     (cs_n),
        .rw_n     (rw_n),
        .a        (a),
        .d_out    (d_out),
        .d_oe     (d_oe),
        .irq_n    (irq_n),
        .warmboot (warmboot),
        .errors   (errors),
        .checks   (checks),
        .seen     (seen)
    );

    always #(cycle_ns / 2) clk = ~clk;

    // Each line holds op, register, write data, expected value and test name
    task automatic load_tests;
        int fd;
        int cnt;
        string line;
        logic [7:0] op;
        logic [7:0] r;
        logic [7:0] d;
        logic [7:0] e;
        logic [8*32-1:0] nm;
        n_lines = 0;
        fd = $fopen("dv/cpubus_tests.txt", "r");
        if (fd == 0) begin
            $display("tests file dv/cpubus_tests.txt could not be opened");
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0)
                break;
            cnt = $sscanf(line, "%c %h %h %h %s", op, r, d, e, nm);
            if (cnt == 5 && n_lines < max_lines) begin  // Comment lines fail the scan
                op_q[n_lines]   = op;
                reg_q[n_lines]  = r;
                data_q[n_lines] = d;
                n_lines = n_lines + 1;
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus-cycle driver with one test line per phi2 period
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed   = 72037;
        clk    = 1'b0;
        rst    = 1'b1;
        cs_n   = 1'b1;
        rw_n   = 1'b1;
        a      = 3'd0;
        d_in   = 8'h00;
        irqs   = 8'h00;
        loaded = 1'b0;
        load_tests();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge phi2_n);  // Align to a cycle start
        for (i = 0; i < n_lines; i = i + 1) begin
            @(posedge clk);
            rnd = $random(seed);
            cs_n <= 1'b0;
            rw_n <= (op_q[i] != "W");
            a    <= reg_q[i][2:0];
            d_in <= (op_q[i] == "W") ? data_q[i] : rnd[7:0];  // Spare data on reads
            irqs <= (op_q[i] == "P") ? data_q[i] : 8'h00;
            @(posedge clk);
            irqs <= 8'h00;     // Single-clock interrupt pulse
            @(posedge phi2_n); // Checker samples as the cycle ends
        end
        @(posedge clk);
        cs_n <= 1'b1;
        repeat (4) @(posedge clk);
        if (seen != n_lines || n_lines == 0)
            $display("only %0d of %0d test lines reached the checker", seen, n_lines);
        $display("checks %0d, errors %0d, lines %0d of %0d", checks, errors, seen, n_lines);
        if (errors == 0 && seen == n_lines && n_lines > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Slowest phi2 period is 32 clocks plus the memory stretch
    initial begin
        wait (loaded);
        #((n_lines * 35 + 40) * cycle_ns);
        $display("timeout, bus cycles stopped after %0d of %0d lines", seen, n_lines);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/cpubus_tests.txt
# op reg wdata expect name, all numbers in hex
# W write, R read d_out, P pulse irqs with wdata during a read, Q read and compare irq_n
W 0 34 00 p0_lo
W 1 12 00 p0_mid
W 2 05 00 p0_hi
W 5 01 00 sel_p1
W 0 78 00 p1_lo
W 2 3a 00 p1_hi
W 6 81 00 ien_set
R 0 00 78 rb_p1_lo
R 2 00 3a rb_p1_hi
W 5 00 00 sel_p0
R 1 00 12 rb_p0_mid
R 2 00 05 rb_p0_hi
R 6 00 81 rb_ien
W 6 00 00 ien_clr
W 0 00 00 p0_lo_100
W 1 01 00 p0_mid_100
W 2 10 00 p0_step1
W 3 a1 00 wr_100
W 3 b2 00 wr_101
R 0 00 02 p0_after_wr
W 0 00 00 p0_rewind
R 3 00 a1 rd_100
R 3 00 b2 rd_101
R 0 00 02 p0_after_rd
W 5 01 00 sel_p1_b
W 0 00 00 p1_lo_200
W 1 02 00 p1_mid_200
W 2 50 00 p1_step16
W 5 00 00 sel_p0_b
W 0 00 00 p0_lo_11200
W 1 12 00 p0_mid_11200
W 2 01 00 p0_nostep
W 4 5a 00 wr_p1_200
R 3 00 5a rd_p0_wrap
W 3 6b 00 wr_p0_nostep
W 4 7c 00 wr_p1_210
W 5 01 00 sel_p1_c
R 0 00 20 p1_lo_step
W 0 00 00 p1_rewind
R 4 00 6b rd_p1_200
R 4 00 7c rd_p1_210
W 5 0e 00 div7
R 5 00 0e rb_div7
R 3 00 6b rd_div7
W 5 00 00 div0
R 3 00 6b rd_div0
P 7 04 04 irq_sticky
Q 6 00 01 irq_masked
W 6 04 00 ien_bit2
Q 6 00 00 irq_active
W 7 04 00 isr_clear
Q 7 00 01 irq_released
R 7 00 00 isr_cleared
W 6 00 00 ien_off
W 5 80 00 warm_set
R 5 00 80 rb_warm
W 5 00 00 warm_clr
R 5 00 00 rb_warm_clr

//--- tb.f
verilog/cpubus_pkg.sv
verilog/phi2_clkgen.sv
verilog/cpubus_regs.sv
verilog/byte_mem_slave.sv
verilog/cpubus_bridge_top.sv
dv/cpubus_checker.sv
dv/tb_cpubus.sv

//--- Makefile
TOP = tb_cpubus

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
